/* Bender.yml */
package:
  name: audio_capture

sources:
  # Shared package first
  - design/audio_pkg.sv
  # Datapath stages
  - design/i2s_receiver.sv
  - design/sample_delay_line.sv
  - design/pdm_modulator.sv
  # Top level
  - design/audio_capture_top.sv
  # Testbench
  - target: test
    files:
      - dv/audio_capture_tb.sv

/* design/audio_capture_top.sv */
`timescale 1ns/1ps

module audio_capture_top #(
  parameter int BCLK_DIV    = 24,   // audio_clk cycles per bclk half period
  parameter int DELAY_DEPTH = 256   // Delay line size, power of two
) (
  input  logic                           audio_clk,
  input  logic                           rst_n,
  input  logic                           mic_data,        // From the microphone
  output logic                           bclk,            // To the microphone
  output logic                           lrcl,            // To the microphone
  input  logic [$clog2(DELAY_DEPTH)-1:0] delay_frames,
  output audio_pkg::audio_sample_t       delayed_sample,
  output logic                           pdm_out          // Speaker bit stream
);

  import audio_pkg::*;

  audio_sample_t captured;  // Receiver to delay line

  // Microphone interface, one left-slot sample per frame
  i2s_receiver #(
    .BCLK_DIV (BCLK_DIV)
  ) u_receiver (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .mic_data  (mic_data),
    .bclk      (bclk),
    .lrcl      (lrcl),
    .captured  (captured)
  );

  // Delay by a chosen number of frames
  sample_delay_line #(
    .DELAY_DEPTH (DELAY_DEPTH)
  ) u_delay (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .delay_frames (delay_frames),
    .captured     (captured),
    .delayed      (delayed_sample)
  );

  // Delayed sample also feeds the speaker
  pdm_modulator u_pdm (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .delayed   (delayed_sample),
    .pdm_out   (pdm_out)
  );

endmodule

/* design/audio_pkg.sv */
package audio_pkg;

  // Sample format
  localparam int SAMPLE_WIDTH = 16;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_data_t;

  // One sample on its way down the chain
  typedef struct packed {
    logic         valid;  // High for one cycle when data is new
    sample_data_t data;
  } audio_sample_t;

  // I2S frame layout, a left and a right slot
  localparam int SLOT_BITS   = 32;             // Bit periods per slot
  localparam int FRAME_BITS  = 2 * SLOT_BITS;  // Bit periods per frame
  localparam int SLOT_CNT_W  = $clog2(SLOT_BITS);
  localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

  // Bit positions inside the left slot, 0 is the period that starts at the lrcl edge.
  // The microphone leaves period 0 empty and sends the MSB first after it
  localparam int MSB_POS = 1;
  localparam int LSB_POS = MSB_POS + SAMPLE_WIDTH - 1;

  // Midscale, maps the signed level onto an unsigned duty value
  localparam logic [SAMPLE_WIDTH-1:0] PDM_OFFSET = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

endpackage

/* design/i2s_receiver.sv */
`timescale 1ns/1ps

module i2s_receiver #(
  parameter int BCLK_DIV = 24  // audio_clk cycles per bclk half period
) (
  input  logic                     audio_clk,
  input  logic                     rst_n,
  input  logic                     mic_data,
  output logic                     bclk,
  output logic                     lrcl,
  output audio_pkg::audio_sample_t captured
);

  import audio_pkg::*;

  localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BCLK_DIV - 1);

  logic [DIV_W-1:0]       div_cnt;
  logic                   half_done;  // Last cycle of a bclk half period
  logic                   bclk_rise;
  logic                   bclk_fall;
  logic [FRAME_CNT_W-1:0] bit_cnt;    // Bit period within the frame
  logic [SLOT_CNT_W-1:0]  slot_pos;
  logic                   left_slot;
  logic                   in_word;
  logic                   take_bit;
  logic                   last_bit;
  sample_data_t           shift_reg;
  logic                   word_done;  // LSB went in on the previous cycle
  logic                   valid_q;
  sample_data_t           data_q;

  // Bit clock divider
  assign half_done = (div_cnt == DIV_LAST);
  assign bclk_rise = half_done && !bclk;
  assign bclk_fall = half_done && bclk;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      bclk    <= 1'b0;
    end else if (half_done) begin
      div_cnt <= '0;
      bclk    <= ~bclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Frame position advances on every bclk fall, wraps after FRAME_BITS
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign lrcl      = bit_cnt[FRAME_CNT_W-1];  // Low for the left slot
  assign slot_pos  = bit_cnt[SLOT_CNT_W-1:0];
  assign left_slot = !lrcl;

  // Sample bits live in periods MSB_POS..LSB_POS of the left slot
  assign in_word  = (slot_pos >= SLOT_CNT_W'(MSB_POS)) && (slot_pos <= SLOT_CNT_W'(LSB_POS));
  assign take_bit = bclk_rise && left_slot && in_word;
  assign last_bit = take_bit && (slot_pos == SLOT_CNT_W'(LSB_POS));

  always_ff @(posedge audio_clk) begin
    if (take_bit) begin
      shift_reg <= {shift_reg[SAMPLE_WIDTH-2:0], mic_data};  // MSB first
    end
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      word_done <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      word_done <= last_bit;
      valid_q   <= word_done;
    end
  end

  // Hold the finished word with its strobe
  always_ff @(posedge audio_clk) begin
    if (word_done) begin
      data_q <= shift_reg;
    end
  end

  assign captured = '{valid: valid_q, data: data_q};

  // One strobe per frame, so never two in a row
  a_single_valid : assert property (
    @(posedge audio_clk) disable iff (!rst_n)
    captured.valid |=> !captured.valid
  ) else $error("i2s_receiver: captured.valid high on consecutive cycles");

endmodule

/* design/pdm_modulator.sv */
`timescale 1ns/1ps

module pdm_modulator (
  input  logic                     audio_clk,
  input  logic                     rst_n,
  input  audio_pkg::audio_sample_t delayed,
  output logic                     pdm_out
);

  import audio_pkg::*;

  sample_data_t            level;   // Last valid sample, held between strobes
  logic [SAMPLE_WIDTH-1:0] offset;  // level + 32768, unsigned duty
  logic [SAMPLE_WIDTH-1:0] acc;
  logic [SAMPLE_WIDTH:0]   sum;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (delayed.valid) begin
      level <= delayed.data;
    end
  end

  // Adding midscale flips the sign bit into an offset binary value
  assign offset = unsigned'(level) + PDM_OFFSET;
  assign sum    = {1'b0, acc} + {1'b0, offset};

  // First order sigma-delta, the carry is the output bit
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= sum[SAMPLE_WIDTH-1:0];
      pdm_out <= sum[SAMPLE_WIDTH];
    end
  end

  // Speaker stays quiet during reset
  a_quiet_in_reset : assert property (
    @(posedge audio_clk)
    !rst_n |-> !pdm_out
  ) else $error("pdm_modulator: pdm_out high while in reset");

endmodule

/* design/sample_delay_line.sv */
`timescale 1ns/1ps

module sample_delay_line #(
  parameter int DELAY_DEPTH = 256  // Stored samples, power of two
) (
  input  logic                           audio_clk,
  input  logic                           rst_n,
  input  logic [$clog2(DELAY_DEPTH)-1:0] delay_frames,
  input  audio_pkg::audio_sample_t       captured,
  output audio_pkg::audio_sample_t       delayed
);

  import audio_pkg::*;

  localparam int ADDR_W = $clog2(DELAY_DEPTH);
  localparam int CNT_W  = ADDR_W + 1;
  localparam logic [CNT_W-1:0] FILL_MAX = CNT_W'(DELAY_DEPTH);

  sample_data_t      mem [DELAY_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  fill_cnt;    // Samples written so far, saturating
  logic              history_ok;  // Requested entry has been written
  sample_data_t      tap_data;
  logic              valid_q;
  sample_data_t      data_q;

  if (DELAY_DEPTH != (1 << ADDR_W)) begin : g_depth_check
    $error("sample_delay_line: DELAY_DEPTH must be a power of two");
  end

  // Read position trails the write pointer, wraps with the buffer
  assign rd_ptr     = wr_ptr - delay_frames;
  assign history_ok = (fill_cnt >= {1'b0, delay_frames});

  always_comb begin
    if (delay_frames == '0) begin
      tap_data = captured.data;  // Zero delay passes the new sample
    end else if (history_ok) begin
      tap_data = mem[rd_ptr];
    end else begin
      tap_data = '0;             // Not enough history yet
    end
  end

  // Storage and output word
  always_ff @(posedge audio_clk) begin
    if (captured.valid) begin
      mem[wr_ptr] <= captured.data;
      data_q      <= tap_data;
    end
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= captured.valid;
      if (captured.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (fill_cnt != FILL_MAX) begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end
    end
  end

  assign delayed = '{valid: valid_q, data: data_q};

  // Fixed one-cycle latency on the strobe
  a_valid_latency : assert property (
    @(posedge audio_clk) disable iff (!rst_n)
    delayed.valid == $past(captured.valid)
  ) else $error("sample_delay_line: output valid is not the input valid one cycle later");

endmodule

/* dv/audio_capture_tb.sv */
`timescale 1ns/1ps

module audio_capture_tb;

  import audio_pkg::*;

  localparam int BCLK_DIV     = 4;
  localparam int DELAY_DEPTH  = 16;
  localparam int DELAY_W      = $clog2(DELAY_DEPTH);
  localparam int FRAME_CYCLES = FRAME_BITS * 2 * BCLK_DIV;
  localparam int WAIT_LIMIT   = 30 * FRAME_CYCLES;  // Cycles allowed for any single wait
  localparam int PDM_WINDOW   = 65536;

  logic               audio_clk = 1'b0;
  logic               rst_n;
  logic               mic_data = 1'b0;
  logic               bclk;
  logic               lrcl;
  logic [DELAY_W-1:0] delay_frames;
  audio_sample_t      delayed_sample;
  logic               pdm_out;

  sample_data_t word_queue[$];  // Words waiting for the microphone model
  sample_data_t sent_words[$];  // One entry per left slot sent
  sample_data_t cur_word = '0;
  logic [31:0]  word_state = 32'd64057;
  logic [31:0]  junk_state = 32'd64057;
  int           slot_pos_m;
  logic         prev_bclk;
  logic         prev_lrcl;

  string test_name = "reset_state";
  int    out_count = 0;
  int    check_count = 0;
  int    error_count = 0;
  int    test_errors = 0;
  int    tests_run = 0;
  bit    timed_out = 1'b0;

  always #10 audio_clk = ~audio_clk;

  audio_capture_top #(
    .BCLK_DIV    (BCLK_DIV),
    .DELAY_DEPTH (DELAY_DEPTH)
  ) UUT (
    .audio_clk      (audio_clk),
    .rst_n          (rst_n),
    .mic_data       (mic_data),
    .bclk           (bclk),
    .lrcl           (lrcl),
    .delay_frames   (delay_frames),
    .delayed_sample (delayed_sample),
    .pdm_out        (pdm_out)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Zero delay passes the new word, otherwise the word d frames back once it exists
  function automatic sample_data_t expected_delayed(input int idx, input int d);
    if (d == 0) begin
      return sent_words[idx];
    end else if (idx >= d) begin
      return sent_words[idx - d];  // Fill count saturates above any legal delay
    end
    return '0;
  endfunction

  // Ones per 65536 cycles follow the offset binary level
  function automatic int expected_ones(input sample_data_t word);
    return int'(word) + 32768;
  endfunction

  task automatic compare_value(input string what, input int expected, input int actual);
    check_count++;
    assert (expected == actual) else begin
      $display("CHECK FAILED %s (%s): expected %0d, actual %0d", test_name, what, expected,
               actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0 && !timed_out) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: FAIL with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic wait_outputs(input int target);
    int cycles;
    cycles = 0;
    while (out_count < target && cycles < WAIT_LIMIT) begin
      @(negedge audio_clk);
      cycles++;
    end
    if (out_count < target) begin
      $display("Timeout in %s: %0d output samples arrived, %0d expected", test_name,
               out_count, target);
      timed_out = 1'b1;
    end
  endtask

  // Counts cycles up to the next bclk rise or the next lrcl change
  task automatic wait_edge(input bit watch_lrcl, output int cycles);
    logic last;
    logic now;
    bit   seen;
    cycles = 0;
    seen   = 1'b0;
    last   = watch_lrcl ? lrcl : bclk;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge audio_clk);
      cycles++;
      now  = watch_lrcl ? lrcl : bclk;
      seen = watch_lrcl ? (now != last) : (!last && now);
      last = now;
    end
    if (!seen) begin
      $display("Timeout in %s: no edge seen on %s", test_name, watch_lrcl ? "lrcl" : "bclk");
      timed_out = 1'b1;
    end
  endtask

  task automatic queue_random_words(input int count);
    repeat (count) begin
      word_state = lcg_step(word_state);
      word_queue.push_back(sample_data_t'(word_state[31:16]));
    end
  endtask

  task automatic check_pdm_level(input sample_data_t word);
    int ones;
    int diff;
    word_queue.push_back(word);
    wait_outputs(out_count + 2);  // Current frame may still carry the old word
    if (!timed_out) begin
      repeat (4) @(negedge audio_clk);
      ones = 0;
      repeat (PDM_WINDOW) begin
        @(negedge audio_clk);
        ones += pdm_out;
      end
      diff = ones - expected_ones(word);
      check_count++;
      assert (diff >= -1 && diff <= 1) else begin
        $display("CHECK FAILED %s (word %0d): expected %0d, actual %0d", test_name, word,
                 expected_ones(word), ones);
        error_count++;
        test_errors++;
      end
    end
  endtask

  // Microphone model, new bit after each bclk fall, MSB in period 1 of the left slot
  always @(negedge audio_clk) begin
    if (!rst_n) begin
      slot_pos_m = 0;
      prev_bclk  = 1'b0;
      prev_lrcl  = 1'b0;
      mic_data   = 1'b0;
    end else begin
      if (prev_bclk && !bclk) begin
        slot_pos_m = (lrcl != prev_lrcl) ? 0 : slot_pos_m + 1;
        prev_lrcl  = lrcl;
        if (!lrcl && slot_pos_m == 1) begin
          if (word_queue.size() > 0) begin
            cur_word = word_queue.pop_front();  // Else repeat the last word
          end
          sent_words.push_back(cur_word);
        end
        junk_state = lcg_step(junk_state);
        if (!lrcl && slot_pos_m >= 1 && slot_pos_m <= SAMPLE_WIDTH) begin
          mic_data = cur_word[SAMPLE_WIDTH - slot_pos_m];
        end else begin
          mic_data = junk_state[20];  // Noise outside the sample bits
        end
      end
      prev_bclk = bclk;
    end
  end

  always @(negedge audio_clk) begin : check_outputs
    sample_data_t exp_data;
    if (rst_n && delayed_sample.valid) begin
      exp_data = expected_delayed(out_count, int'(delay_frames));
      compare_value($sformatf("sample %0d", out_count), exp_data, delayed_sample.data);
      out_count++;
    end
  end

  initial begin
    int cycles;
    rst_n        = 1'b0;
    delay_frames = '0;
    repeat (16) @(negedge audio_clk);

    start_test("reset_state");
    compare_value("bclk in reset", 0, bclk);
    compare_value("lrcl in reset", 0, lrcl);
    compare_value("pdm_out in reset", 0, pdm_out);
    compare_value("valid in reset", 0, delayed_sample.valid);
    rst_n = 1'b1;
    @(negedge audio_clk);
    compare_value("bclk after reset", 0, bclk);
    compare_value("lrcl after reset", 0, lrcl);
    compare_value("pdm_out after reset", 0, pdm_out);
    compare_value("valid after reset", 0, delayed_sample.valid);
    finish_test();

    start_test("i2s_clocks");
    wait_edge(1'b0, cycles);
    wait_edge(1'b0, cycles);
    compare_value("bclk period", 2 * BCLK_DIV, cycles);
    wait_edge(1'b1, cycles);
    wait_edge(1'b1, cycles);
    compare_value("lrcl half period", SLOT_BITS * 2 * BCLK_DIV, cycles);
    finish_test();

    if (!timed_out) begin
      start_test("delay_zero");
      queue_random_words(20);
      wait_outputs(out_count + 21);
      finish_test();
    end

    if (!timed_out) begin
      start_test("delay_five");
      delay_frames = DELAY_W'(5);
      queue_random_words(20);
      wait_outputs(out_count + 21);
      finish_test();
    end

    if (!timed_out) begin
      start_test("pdm_density");
      delay_frames = '0;
      check_pdm_level(-16'sd12000);
      if (!timed_out) check_pdm_level(16'sd0);
      if (!timed_out) check_pdm_level(16'sd20000);
      finish_test();
    end

    $display("checks: %0d, errors: %0d, tests run: %0d", check_count, error_count, tests_run);
    if (error_count == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
design/audio_pkg.sv
design/i2s_receiver.sv
design/sample_delay_line.sv
design/pdm_modulator.sv
design/audio_capture_top.sv
dv/audio_capture_tb.sv
